// File: source/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// Entries per byte FIFO
`define UART_FIFO_DEPTH 16

// Block RAM port
`define UART_MEM_WIDTH  32
`define UART_ADDR_WIDTH 8

// Register word addresses, command codes reuse these values
`define UART_CTRL_ADDR   0
`define UART_DIV_ADDR    1
`define UART_PARITY_ADDR 2
`define UART_TX_ADDR     3
`define UART_RX_ADDR     4

`endif

// File: source/uart_pkg.sv
`include "uart_settings.svh"

package uart_pkg;

    typedef logic [`UART_MEM_WIDTH-1:0]  mem_word_t;
    typedef logic [`UART_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [15:0]                 clk_div_t;
    typedef logic [7:0]                  uart_byte_t;

    // Bit 0 enable, bit 1 odd
    typedef struct packed {
        logic odd;
        logic enable;
    } parity_cfg_t;

    typedef struct packed {
        logic       valid;
        uart_byte_t data;
        logic       error;
    } byte_stream_t;

    // Each code matches the address of the register it acts on
    typedef enum logic [2:0] {
        CMD_NONE   = 3'd`UART_CTRL_ADDR,
        CMD_DIV    = 3'd`UART_DIV_ADDR,
        CMD_PARITY = 3'd`UART_PARITY_ADDR,
        CMD_TX     = 3'd`UART_TX_ADDR,
        CMD_RX     = 3'd`UART_RX_ADDR
    } cmd_e;

endpackage

// File: source/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
    import uart_pkg::*;
(
    input  logic         clk_i,
    input  logic         arstn_i,
    input  clk_div_t     clk_div_i,
    input  parity_cfg_t  parity_i,
    input  byte_stream_t s_i,
    output logic         s_ready_o,
    output logic         uart_tx_o
);

typedef enum logic [2:0] {
    IDLE,
    START,
    DATA,
    PARITY,
    STOP
} state_e;

state_e     state;
clk_div_t   div_q;
clk_div_t   cnt;
logic       par_en_q;
logic       par_bit_q;
logic [2:0] bit_idx;
uart_byte_t shift_q;
logic       tx_q;
logic       tick;

// Last cycle of the current bit
assign tick      = (cnt == div_q - 1'b1);
assign s_ready_o = (state == IDLE);
assign uart_tx_o = tx_q;

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (~arstn_i) begin
        state     <= IDLE;
        tx_q      <= 1'b1;
        cnt       <= '0;
        div_q     <= '0;
        bit_idx   <= '0;
        shift_q   <= '0;
        par_en_q  <= 1'b0;
        par_bit_q <= 1'b0;
    end else begin
        cnt <= tick ? '0 : cnt + 1'b1;
        case (state)
            IDLE: begin
                tx_q <= 1'b1;
                if (s_i.valid) begin
                    // Settings are frozen for the whole frame
                    div_q     <= clk_div_i;
                    par_en_q  <= parity_i.enable;
                    par_bit_q <= ^s_i.data ^ parity_i.odd;
                    shift_q   <= s_i.data;
                    cnt       <= '0;
                    tx_q      <= 1'b0;
                    state     <= START;
                end
            end
            START: begin
                if (tick) begin
                    tx_q    <= shift_q[0];
                    bit_idx <= '0;
                    state   <= DATA;
                end
            end
            DATA: begin
                if (tick) begin
                    if (bit_idx == 3'd7) begin
                        tx_q  <= par_en_q ? par_bit_q : 1'b1;
                        state <= par_en_q ? PARITY : STOP;
                    end else begin
                        tx_q    <= shift_q[1];
                        shift_q <= shift_q >> 1;
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
            end
            PARITY: begin
                if (tick) begin
                    tx_q  <= 1'b1;
                    state <= STOP;
                end
            end
            STOP: begin
                if (tick) begin
                    state <= IDLE;
                end
            end
            default: state <= IDLE;
        endcase
    end
end

endmodule

// File: source/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
    import uart_pkg::*;
(
    input  logic         clk_i,
    input  logic         arstn_i,
    input  clk_div_t     clk_div_i,
    input  parity_cfg_t  parity_i,
    input  logic         uart_rx_i,
    output byte_stream_t m_o
);

typedef enum logic [2:0] {
    IDLE,
    START,
    DATA,
    PARITY,
    STOP
} state_e;

state_e      state;
logic [1:0]  sync_q;
logic        line_q;
logic        rx_line;
logic        fall;
clk_div_t    div_q;
clk_div_t    cnt;
parity_cfg_t par_q;
logic [2:0]  bit_idx;
uart_byte_t  shift_q;
logic        par_err_q;
logic        valid_q;
logic        err_q;
logic        tick;
logic        half;

// Two-stage synchronizer on the serial line
always_ff @(posedge clk_i or negedge arstn_i) begin
    if (~arstn_i) begin
        sync_q <= 2'b11;
        line_q <= 1'b1;
    end else begin
        sync_q <= {sync_q[0], uart_rx_i};
        line_q <= sync_q[1];
    end
end

assign rx_line = sync_q[1];
assign fall    = line_q & ~rx_line;
assign tick    = (cnt == div_q - 1'b1);
assign half    = (cnt == (div_q >> 1) - 1'b1);

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (~arstn_i) begin
        state     <= IDLE;
        cnt       <= '0;
        div_q     <= '0;
        par_q     <= '0;
        bit_idx   <= '0;
        shift_q   <= '0;
        par_err_q <= 1'b0;
        valid_q   <= 1'b0;
        err_q     <= 1'b0;
    end else begin
        valid_q <= 1'b0;
        cnt     <= cnt + 1'b1;
        case (state)
            IDLE: begin
                if (fall) begin
                    div_q     <= clk_div_i;
                    par_q     <= parity_i;
                    par_err_q <= 1'b0;
                    cnt       <= '0;
                    state     <= START;
                end
            end
            START: begin
                // Middle of the start bit, later samples are one period apart
                if (half) begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    state   <= rx_line ? IDLE : DATA;
                end
            end
            DATA: begin
                if (tick) begin
                    cnt     <= '0;
                    shift_q <= {rx_line, shift_q[7:1]};
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) begin
                        state <= par_q.enable ? PARITY : STOP;
                    end
                end
            end
            PARITY: begin
                if (tick) begin
                    cnt       <= '0;
                    par_err_q <= rx_line ^ (^shift_q) ^ par_q.odd;
                    state     <= STOP;
                end
            end
            STOP: begin
                if (tick) begin
                    valid_q <= 1'b1;
                    err_q   <= par_err_q | ~rx_line;
                    state   <= IDLE;
                end
            end
            default: state <= IDLE;
        endcase
    end
end

assign m_o = '{valid: valid_q, data: shift_q, error: err_q};

endmodule

// File: source/byte_fifo.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module byte_fifo
    import uart_pkg::*;
(
    input  logic         clk_i,
    input  logic         arstn_i,
    input  byte_stream_t s_i,
    output logic         s_ready_o,
    output byte_stream_t m_o,
    input  logic         m_ready_i
);

localparam int DEPTH     = `UART_FIFO_DEPTH;
localparam int PTR_WIDTH = $clog2(DEPTH);
localparam int CNT_WIDTH = $clog2(DEPTH + 1);

uart_byte_t           data_mem [DEPTH];
logic                 err_mem  [DEPTH];
logic [PTR_WIDTH-1:0] wr_ptr;
logic [PTR_WIDTH-1:0] rd_ptr;
logic [CNT_WIDTH-1:0] count;
logic                 push;
logic                 pop;

assign s_ready_o = (count != CNT_WIDTH'(DEPTH));
assign push      = s_i.valid & s_ready_o;
assign pop       = m_o.valid & m_ready_i;

assign m_o = '{valid: (count != '0), data: data_mem[rd_ptr], error: err_mem[rd_ptr]};

always_ff @(posedge clk_i) begin
    if (push) begin
        data_mem[wr_ptr] <= s_i.data;
        err_mem[wr_ptr]  <= s_i.error;
    end
end

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (~arstn_i) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (push) begin
            wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        count <= count + CNT_WIDTH'(push) - CNT_WIDTH'(pop);
    end
end

a_count_bound: assert property (@(posedge clk_i) disable iff (~arstn_i)
    count <= CNT_WIDTH'(DEPTH));

endmodule

// File: source/uart_mem_sequencer.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_mem_sequencer
    import uart_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         arstn_i,
    input  mem_word_t                    data_i,
    output mem_addr_t                    addr_o,
    output mem_word_t                    data_o,
    output logic [`UART_MEM_WIDTH/8-1:0] wr_en_o,
    output byte_stream_t                 tx_o,
    input  logic                         tx_ready_i,
    input  byte_stream_t                 rx_i,
    output logic                         rx_ready_o,
    output clk_div_t                     clk_div_o,
    output parity_cfg_t                  parity_o
);

typedef enum logic [2:0] {
    IDLE,
    FETCH,
    TX_PUSH,
    RX_WAIT,
    RX_WRITE,
    ACK,
    SETTLE
} state_e;

state_e      state;
cmd_e        cmd_q;
cmd_e        cmd_in;
logic        lat_cnt;
logic        tx_valid;
uart_byte_t  tx_data;
clk_div_t    clk_div_q;
parity_cfg_t parity_q;

// Anything that is not a known code counts as no command
always_comb begin
    case (data_i)
        mem_word_t'(CMD_DIV):    cmd_in = CMD_DIV;
        mem_word_t'(CMD_PARITY): cmd_in = CMD_PARITY;
        mem_word_t'(CMD_TX):     cmd_in = CMD_TX;
        mem_word_t'(CMD_RX):     cmd_in = CMD_RX;
        default:                 cmd_in = CMD_NONE;
    endcase
end

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (~arstn_i) begin
        state     <= IDLE;
        cmd_q     <= CMD_NONE;
        lat_cnt   <= 1'b0;
        addr_o    <= mem_addr_t'(`UART_CTRL_ADDR);
        data_o    <= '0;
        wr_en_o   <= '0;
        tx_valid  <= 1'b0;
        tx_data   <= '0;
        clk_div_q <= 16'd16;
        parity_q  <= '0;
    end else begin
        case (state)
            IDLE: begin
                addr_o  <= mem_addr_t'(`UART_CTRL_ADDR);
                wr_en_o <= '0;
                lat_cnt <= 1'b0;
                cmd_q   <= cmd_in;
                case (cmd_in)
                    CMD_DIV, CMD_PARITY, CMD_TX: begin
                        addr_o <= mem_addr_t'(cmd_in);
                        state  <= FETCH;
                    end
                    CMD_RX:  state <= RX_WAIT;
                    default: state <= IDLE;
                endcase
            end
            FETCH: begin
                // Data for the register address shows up on the second cycle
                if (!lat_cnt) begin
                    lat_cnt <= 1'b1;
                end else begin
                    addr_o <= mem_addr_t'(`UART_CTRL_ADDR);
                    data_o <= mem_word_t'(CMD_NONE);
                    if (cmd_q == CMD_TX) begin
                        tx_data  <= data_i[7:0];
                        tx_valid <= 1'b1;
                        state    <= TX_PUSH;
                    end else begin
                        if (cmd_q == CMD_DIV) begin
                            clk_div_q <= data_i[15:0];
                        end else begin
                            parity_q <= parity_cfg_t'(data_i[1:0]);
                        end
                        wr_en_o <= '1;
                        state   <= ACK;
                    end
                end
            end
            TX_PUSH: begin
                if (tx_ready_i) begin
                    tx_valid <= 1'b0;
                    wr_en_o  <= '1;
                    state    <= ACK;
                end
            end
            RX_WAIT: begin
                if (rx_i.valid) begin
                    addr_o  <= mem_addr_t'(`UART_RX_ADDR);
                    data_o  <= mem_word_t'({rx_i.error, rx_i.data});
                    wr_en_o <= '1;
                    state   <= RX_WRITE;
                end
            end
            RX_WRITE: begin
                addr_o <= mem_addr_t'(`UART_CTRL_ADDR);
                data_o <= mem_word_t'(CMD_NONE);
                state  <= ACK;
            end
            ACK: begin
                wr_en_o <= '0;
                lat_cnt <= 1'b0;
                state   <= SETTLE;
            end
            SETTLE: begin
                // Let the cleared control word reach data_i before polling
                if (lat_cnt) begin
                    state <= IDLE;
                end else begin
                    lat_cnt <= 1'b1;
                end
            end
            default: state <= IDLE;
        endcase
    end
end

assign tx_o       = '{valid: tx_valid, data: tx_data, error: 1'b0};
assign rx_ready_o = (state == RX_WAIT);
assign clk_div_o  = clk_div_q;
assign parity_o   = parity_q;

a_wr_en_whole_word: assert property (@(posedge clk_i) disable iff (~arstn_i)
    (wr_en_o == '0) || (wr_en_o == '1));

a_tx_hold: assert property (@(posedge clk_i) disable iff (~arstn_i)
    tx_o.valid && !tx_ready_i |=> tx_o.valid && $stable(tx_o.data));

endmodule

// File: source/uart_bram_ctrl.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_bram_ctrl
    import uart_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         arstn_i,
    input  logic                         uart_rx_i,
    output logic                         uart_tx_o,
    input  mem_word_t                    data_i,
    output mem_word_t                    data_o,
    output mem_addr_t                    addr_o,
    output logic [`UART_MEM_WIDTH/8-1:0] wr_en_o
);

byte_stream_t tx_req;
logic         tx_req_ready;
byte_stream_t tx_out;
logic         tx_out_ready;
byte_stream_t rx_frame;
byte_stream_t rx_out;
logic         rx_out_ready;
clk_div_t     clk_div;
parity_cfg_t  parity;

uart_mem_sequencer i_uart_mem_sequencer (
    .clk_i      (clk_i       ),
    .arstn_i    (arstn_i     ),
    .data_i     (data_i      ),
    .addr_o     (addr_o      ),
    .data_o     (data_o      ),
    .wr_en_o    (wr_en_o     ),
    .tx_o       (tx_req      ),
    .tx_ready_i (tx_req_ready),
    .rx_i       (rx_out      ),
    .rx_ready_o (rx_out_ready),
    .clk_div_o  (clk_div     ),
    .parity_o   (parity      )
);

byte_fifo i_byte_fifo_tx (
    .clk_i     (clk_i       ),
    .arstn_i   (arstn_i     ),
    .s_i       (tx_req      ),
    .s_ready_o (tx_req_ready),
    .m_o       (tx_out      ),
    .m_ready_i (tx_out_ready)
);

// A full RX FIFO drops the byte, the receiver never stalls
byte_fifo i_byte_fifo_rx (
    .clk_i     (clk_i       ),
    .arstn_i   (arstn_i     ),
    .s_i       (rx_frame    ),
    .s_ready_o (            ),
    .m_o       (rx_out      ),
    .m_ready_i (rx_out_ready)
);

uart_tx i_uart_tx (
    .clk_i     (clk_i       ),
    .arstn_i   (arstn_i     ),
    .clk_div_i (clk_div     ),
    .parity_i  (parity      ),
    .s_i       (tx_out      ),
    .s_ready_o (tx_out_ready),
    .uart_tx_o (uart_tx_o   )
);

uart_rx i_uart_rx (
    .clk_i     (clk_i    ),
    .arstn_i   (arstn_i  ),
    .clk_div_i (clk_div  ),
    .parity_i  (parity   ),
    .uart_rx_i (uart_rx_i),
    .m_o       (rx_frame )
);

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic arstn_o
);

// 40 ns period
initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
end

initial begin
    arstn_o = 1'b0;
    repeat (3) @(posedge clk_o);
    arstn_o <= 1'b1;
end

endmodule

// File: verification/tb_uart_bram_ctrl.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module tb_uart_bram_ctrl
    import uart_pkg::*;
();

localparam int BIT_CYCLES     = 8;
localparam int NUM_FRAMES     = 12;
localparam int FRAME_BITS     = 11;
localparam int MAX_DIV        = 16;
localparam int TIMEOUT_CYCLES = 2 * NUM_FRAMES * FRAME_BITS * MAX_DIV + 2000;

localparam logic [3:0] RX_IDX = 4'(`UART_RX_ADDR);

logic       clk_i;
logic       arstn_i;
logic       uart_rx_i;
logic       uart_tx_o;
mem_word_t  bram_rdata;
mem_word_t  data_o;
mem_addr_t  addr_o;
logic [3:0] wr_en_o;

// 16-word block RAM model with a host side port for the stimulus
mem_word_t  mem [16];
logic       host_we;
logic [3:0] host_addr;
mem_word_t  host_data;
logic [4:0] idx;

logic [31:0] lcg_state;
string       test_name;

tb_clock_gen i_tb_clock_gen (
    .clk_o   (clk_i  ),
    .arstn_o (arstn_i)
);

uart_bram_ctrl i_uart_bram_ctrl (
    .clk_i     (clk_i     ),
    .arstn_i   (arstn_i   ),
    .uart_rx_i (uart_rx_i ),
    .uart_tx_o (uart_tx_o ),
    .data_i    (bram_rdata),
    .data_o    (data_o    ),
    .addr_o    (addr_o    ),
    .wr_en_o   (wr_en_o   )
);

initial begin
    for (idx = 5'd0; idx < 5'd16; idx++) begin
        mem[idx[3:0]] = {8'h5A, 8'h00, 4'h0, idx[3:0], 4'h0, idx[3:0]};
    end
    bram_rdata = '0;
end

// Read data belongs to the address of the previous cycle
always @(posedge clk_i) begin
    if (host_we) begin
        mem[host_addr] <= host_data;
    end
    if (wr_en_o == 4'hF) begin
        mem[addr_o[3:0]] <= data_o;
    end
    bram_rdata <= mem[addr_o[3:0]];
end

task automatic report_mismatch(input string check, input logic [31:0] expected,
                               input logic [31:0] actual);
    $display("FAILED %s (%s): expected 0x%0h, actual 0x%0h", test_name, check, expected,
             actual);
    $display("Test failed");
    $fatal(1, "stopped at the first error");
endtask

function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

task automatic random_byte(output uart_byte_t b);
    lcg_state = lcg_step(lcg_state);
    b = lcg_state[23:16];
endtask

// Flip the top bit if needed so the byte holds an even number of ones
function automatic uart_byte_t even_parity_byte(input uart_byte_t b);
    return (^b) ? (b ^ 8'h80) : b;
endfunction

function automatic logic expected_parity(input uart_byte_t b, input logic odd);
    return odd ? ~(^b) : (^b);
endfunction

// Line level of slot k in a frame of start bit, 8 data bits LSB first, parity and stop bit
function automatic logic frame_bit(input uart_byte_t b, input logic par_en,
                                   input logic par_bit, input int k);
    uart_byte_t shifted;
    if (k == 0) begin
        return 1'b0;
    end else if (k <= 8) begin
        shifted = b >> (k - 1);
        return shifted[0];
    end else if (k == 9 && par_en) begin
        return par_bit;
    end
    return 1'b1;
endfunction

task automatic write_word(input mem_addr_t addr, input mem_word_t value);
    @(posedge clk_i);
    host_we   <= 1'b1;
    host_addr <= addr[3:0];
    host_data <= value;
    @(posedge clk_i);
    host_we   <= 1'b0;
endtask

task automatic post_command(input cmd_e cmd);
    write_word(mem_addr_t'(`UART_CTRL_ADDR), mem_word_t'(cmd));
endtask

task automatic wait_ack();
    do begin
        @(negedge clk_i);
    end while (!(wr_en_o == 4'hF && addr_o == mem_addr_t'(`UART_CTRL_ADDR)));
    // Let the acknowledge write reach the memory model
    @(negedge clk_i);
endtask

// Each bit must hold its level for exactly BIT_CYCLES cycles
task automatic check_frame(input uart_byte_t b, input logic par_en, input logic odd);
    int   nbits;
    int   k;
    int   c;
    logic exp_bit;
    nbits = par_en ? 11 : 10;
    do begin
        @(negedge clk_i);
    end while (uart_tx_o !== 1'b0);
    for (k = 0; k < nbits; k++) begin
        for (c = 0; c < BIT_CYCLES; c++) begin
            if (k != 0 || c != 0) begin
                @(negedge clk_i);
            end
            exp_bit = frame_bit(b, par_en, expected_parity(b, odd), k);
            assert (uart_tx_o === exp_bit)
                else report_mismatch($sformatf("tx slot %0d", k), {31'h0, exp_bit},
                                     {31'h0, uart_tx_o});
        end
    end
endtask

task automatic send_frame(input uart_byte_t b, input logic par_en, input logic par_bit);
    int nbits;
    int k;
    nbits = par_en ? 11 : 10;
    for (k = 0; k < nbits; k++) begin
        @(posedge clk_i);
        uart_rx_i <= frame_bit(b, par_en, par_bit, k);
        repeat (BIT_CYCLES - 1) @(posedge clk_i);
    end
    // Idle line gives the receiver time to finish the stop bit
    repeat (BIT_CYCLES) @(posedge clk_i);
endtask

task automatic transmit_byte(input uart_byte_t b, input logic par_en, input logic odd);
    write_word(mem_addr_t'(`UART_TX_ADDR), {24'h0, b});
    fork
        begin
            post_command(CMD_TX);
            wait_ack();
        end
        check_frame(b, par_en, odd);
    join
endtask

task automatic receive_byte(input uart_byte_t b, input logic par_en, input logic par_bit,
                            input logic exp_err);
    write_word(mem_addr_t'(`UART_RX_ADDR), 32'hFFFF_FFFF);
    send_frame(b, par_en, par_bit);
    post_command(CMD_RX);
    wait_ack();
    assert (mem[RX_IDX] == {23'h0, exp_err, b})
        else report_mismatch("rx word", {23'h0, exp_err, b}, mem[RX_IDX]);
endtask

a_reset_state: assert property (@(negedge clk_i)
    (!arstn_i || $past(!arstn_i)) |->
        (uart_tx_o && wr_en_o == 4'h0 && addr_o == mem_addr_t'(`UART_CTRL_ADDR)))
    else report_mismatch("reset outputs", 32'h0000_1000, {19'h0, uart_tx_o, wr_en_o, addr_o});

a_ack_clears: assert property (@(negedge clk_i) disable iff (!arstn_i)
    (wr_en_o == 4'hF && addr_o == mem_addr_t'(`UART_CTRL_ADDR)) |-> data_o == '0)
    else report_mismatch("acknowledge write", 32'h0, data_o);

initial begin
    uart_byte_t b;
    uart_byte_t tx_bytes [4];
    int         i;
    int         j;
    uart_rx_i = 1'b1;
    host_we   = 1'b0;
    host_addr = '0;
    host_data = '0;
    lcg_state = 32'd14;
    test_name = "reset";
    @(posedge arstn_i);
    repeat (2) @(posedge clk_i);

    test_name = "configure";
    write_word(mem_addr_t'(`UART_DIV_ADDR), 32'd8);
    post_command(CMD_DIV);
    wait_ack();
    // Enable in bit 0 and odd in bit 1
    write_word(mem_addr_t'(`UART_PARITY_ADDR), 32'h3);
    post_command(CMD_PARITY);
    wait_ack();

    test_name = "transmit";
    for (i = 0; i < 4; i++) begin
        random_byte(b);
        transmit_byte(b, 1'b1, 1'b1);
    end

    test_name = "transmit buffering";
    for (i = 0; i < 4; i++) begin
        random_byte(tx_bytes[i]);
    end
    fork
        for (i = 0; i < 4; i++) begin
            write_word(mem_addr_t'(`UART_TX_ADDR), {24'h0, tx_bytes[i]});
            post_command(CMD_TX);
            wait_ack();
        end
        for (j = 0; j < 4; j++) begin
            check_frame(tx_bytes[j], 1'b1, 1'b1);
        end
    join

    test_name = "receive";
    random_byte(b);
    receive_byte(b, 1'b1, expected_parity(b, 1'b1), 1'b0);
    random_byte(b);
    receive_byte(b, 1'b1, ~expected_parity(b, 1'b1), 1'b1);

    // Even bytes make a stray parity bit show up as a low slot or an error flag
    test_name = "parity disabled";
    write_word(mem_addr_t'(`UART_PARITY_ADDR), 32'h0);
    post_command(CMD_PARITY);
    wait_ack();
    random_byte(b);
    transmit_byte(even_parity_byte(b), 1'b0, 1'b0);
    random_byte(b);
    receive_byte(even_parity_byte(b), 1'b0, 1'b0, 1'b0);

    $display("Test completed successfully");
    $finish;
end

initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $fatal(1, "watchdog expired");
end

endmodule

// File: verilog.f
+incdir+source
source/uart_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/byte_fifo.sv
source/uart_mem_sequencer.sv
source/uart_bram_ctrl.sv
verification/tb_clock_gen.sv
verification/tb_uart_bram_ctrl.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_uart_bram_ctrl
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation passed"; \
	else echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
